/* Bender.yml */
package:
  name: lsu

sources:
  - lsu_pkg.sv
  - lsu_decode.sv
  - data_mem.sv
  - load_format.sv
  - lsu_top.sv
  - target: simulation
    files:
      - lsu_checker.sv
      - tb_lsu_top.sv

/* data_mem.sv */
`timescale 1ns/100ps
`default_nettype none

module data_mem import lsu_pkg::*; (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     cmd_valid_i,
    input  mem_cmd_t cmd_i,
    output logic     mrsp_valid_o,
    output mem_rsp_t mrsp_o
);

    // 128 KiB, one byte per entry
    logic [7:0]        mem [MEM_BYTES];

    logic [MEM_AW-1:0] lane_addr [4];
    logic [3:0]        lane_en;
    logic [3:0]        lane_we;
    logic              do_store;

    // Byte index of every lane
    // Lanes past the top wrap, which only happens for bytes nobody uses
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            lane_addr[k] = cmd_i.addr[MEM_AW-1:0] + MEM_AW'(k);
        end
    end

    // Lanes touched by the access size
    always_comb begin
        case (cmd_i.size)
            SZ_BYTE: lane_en = 4'b0001;
            SZ_HALF: lane_en = 4'b0011;
            default: lane_en = 4'b1111;
        endcase
    end

    // Erroneous accesses never write
    assign do_store = cmd_valid_i & cmd_i.is_store & ~cmd_i.err;
    assign lane_we  = do_store ? lane_en : 4'b0000;

    // Store path, one byte lane at a time
    always_ff @(posedge clk) begin
        for (int k = 0; k < 4; k++) begin
            if (lane_we[k]) begin
                mem[lane_addr[k]] <= cmd_i.wdata[8*k +: 8];
            end
        end
    end

    // Load path reads all four bytes, formatter keeps what it needs
    always_ff @(posedge clk) begin
        if (cmd_valid_i) begin
            for (int k = 0; k < 4; k++) begin
                mrsp_o.rword[8*k +: 8] <= mem[lane_addr[k]];
            end
            mrsp_o.size     <= cmd_i.size;
            mrsp_o.sign_ext <= cmd_i.sign_ext;
            mrsp_o.is_store <= cmd_i.is_store;
            mrsp_o.rd       <= cmd_i.rd;
            mrsp_o.err      <= cmd_i.err;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mrsp_valid_o <= 1'b0;
        end else begin
            mrsp_valid_o <= cmd_valid_i;
        end
    end

endmodule

`default_nettype wire

/* load_format.sv */
`timescale 1ns/100ps
`default_nettype none

module load_format import lsu_pkg::*; (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     mrsp_valid_i,
    input  mem_rsp_t mrsp_i,
    output logic     rsp_valid_o,
    output lsu_rsp_t rsp_o
);

    logic        fill_b;    // Top bit of a byte load, if signed
    logic        fill_h;    // Same for a half load
    logic [31:0] rdata_d;

    assign fill_b = mrsp_i.sign_ext & mrsp_i.rword[7];
    assign fill_h = mrsp_i.sign_ext & mrsp_i.rword[15];

    always_comb begin
        case (mrsp_i.size)
            SZ_BYTE: rdata_d = {{24{fill_b}}, mrsp_i.rword[7:0]};
            SZ_HALF: rdata_d = {{16{fill_h}}, mrsp_i.rword[15:0]};
            default: rdata_d = mrsp_i.rword;
        endcase

        // Error wins over everything
        if (mrsp_i.err) begin
            rdata_d = ERR_PATTERN;
        end else if (mrsp_i.is_store) begin
            rdata_d = 32'h0;
        end
    end

    always_ff @(posedge clk) begin
        if (mrsp_valid_i) begin
            rsp_o.rdata    <= rdata_d;
            rsp_o.rd       <= mrsp_i.rd;
            rsp_o.is_store <= mrsp_i.is_store;
            rsp_o.err      <= mrsp_i.err;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= mrsp_valid_i;
        end
    end

endmodule

`default_nettype wire

/* lsu_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_checker import lsu_pkg::*; (
    input logic     clk,
    input logic     arst_n_i,
    input logic     req_valid_i,
    input logic     rsp_valid_o,
    input lsu_rsp_t rsp_o
);

    int unsigned fail_cnt = 0;      // Failed assertions so far

    // Fixed latency since nothing can stall the pipe
    a_req_to_rsp: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        req_valid_i |-> ##PIPE_LATENCY rsp_valid_o
    ) else begin
        fail_cnt++;
        $error("request got no response %0d cycles later", PIPE_LATENCY);
    end

    // Every response traces back to a request
    a_no_stray_rsp: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        rsp_valid_o |-> $past(req_valid_i, PIPE_LATENCY)
    ) else begin
        fail_cnt++;
        $error("rsp_valid_o high with no request %0d cycles before", PIPE_LATENCY);
    end

    a_idle_in_reset: assert property (
        @(posedge clk)
        !arst_n_i |-> !rsp_valid_o
    ) else begin
        fail_cnt++;
        $error("rsp_valid_o high while reset is asserted");
    end

    // Error responses carry the fixed pattern
    a_err_pattern: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        rsp_valid_o && rsp_o.err |-> rsp_o.rdata == ERR_PATTERN
    ) else begin
        fail_cnt++;
        $error("[ERROR] rsp_o.rdata: expected 0x%h, got 0x%h", ERR_PATTERN, rsp_o.rdata);
    end

endmodule

`default_nettype wire

/* lsu_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_decode import lsu_pkg::*; (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     req_valid_i,
    input  lsu_req_t req_i,
    output logic     cmd_valid_o,
    output mem_cmd_t cmd_o
);

    logic [6:0]  opcode;
    logic        is_load;
    logic        is_store;
    logic [2:0]  funct3;
    logic [31:0] imm;
    logic [31:0] addr;
    size_e       size;
    logic        sign_ext;
    logic        f3_ok;
    logic        range_ok;
    logic        align_ok;
    mem_cmd_t    cmd_d;

    // Opcode sits at the same bits in both views
    assign opcode   = req_i.instr.i.opcode;
    assign is_load  = (opcode == OPC_LOAD);
    assign is_store = (opcode == OPC_STORE);

    // Pick the instruction view and build the immediate
    always_comb begin
        if (is_store) begin
            funct3 = req_i.instr.s.funct3;
            imm    = {{20{req_i.instr.s.imm_hi[6]}}, req_i.instr.s.imm_hi,
                      req_i.instr.s.imm_lo};
        end else begin
            funct3 = req_i.instr.i.funct3;
            imm    = {{20{req_i.instr.i.imm[11]}}, req_i.instr.i.imm};
        end
    end

    assign addr = req_i.rs1_val + imm;

    // Access size and sign from funct3
    always_comb begin
        size     = SZ_WORD;
        sign_ext = 1'b0;
        f3_ok    = 1'b1;
        case (funct3)
            F3_B: begin
                size     = SZ_BYTE;
                sign_ext = is_load;
            end
            F3_H: begin
                size     = SZ_HALF;
                sign_ext = is_load;
            end
            F3_W:  size = SZ_WORD;
            F3_BU: begin
                size  = SZ_BYTE;
                f3_ok = is_load;    // No unsigned store
            end
            F3_HU: begin
                size  = SZ_HALF;
                f3_ok = is_load;
            end
            default: f3_ok = 1'b0;
        endcase
    end

    assign range_ok = (addr <= TOP_ADDR);

    // Natural alignment
    always_comb begin
        case (size)
            SZ_HALF: align_ok = ~addr[0];
            SZ_WORD: align_ok = (addr[1:0] == 2'b00);
            default: align_ok = 1'b1;
        endcase
    end

    always_comb begin
        cmd_d.addr     = addr;
        cmd_d.size     = size;
        cmd_d.is_store = is_store;
        cmd_d.sign_ext = sign_ext;
        cmd_d.wdata    = req_i.rs2_val;
        cmd_d.rd       = is_store ? 5'd0 : req_i.instr.i.rd;   // Stores write no register
        cmd_d.err      = ~(is_load | is_store) | ~f3_ok | ~range_ok | ~align_ok;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cmd_valid_o <= 1'b0;
        end else begin
            cmd_valid_o <= req_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            cmd_o <= cmd_d;
        end
    end

endmodule

`default_nettype wire

/* lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    // Address map of the data memory, 0x0 up to 0x1FFFF
    localparam int unsigned MEM_BYTES = 131072;
    localparam logic [31:0] TOP_ADDR  = 32'h0001_FFFF;
    localparam int unsigned MEM_AW    = 17;         // Byte index width

    // RV32I major opcodes
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    // funct3 codes shared by loads and stores
    localparam logic [2:0] F3_B  = 3'b000;  // LB / SB
    localparam logic [2:0] F3_H  = 3'b001;  // LH / SH
    localparam logic [2:0] F3_W  = 3'b010;  // LW / SW
    localparam logic [2:0] F3_BU = 3'b100;  // LBU, load only
    localparam logic [2:0] F3_HU = 3'b101;  // LHU, load only

    localparam logic [31:0] ERR_PATTERN = 32'hDEAD_BEEF;

    // Request to response, in cycles
    localparam int unsigned PIPE_LATENCY = 3;

    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } size_e;

    // I-type view, used for loads
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_t;

    // S-type view, used for stores
    typedef struct packed {
        logic [6:0] imm_hi;     // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;     // imm[4:0]
        logic [6:0] opcode;
    } instr_s_t;

    typedef union packed {
        instr_i_t i;
        instr_s_t s;
    } instr_u;

    typedef struct packed {
        instr_u      instr;
        logic [31:0] rs1_val;   // Base register
        logic [31:0] rs2_val;   // Store data
    } lsu_req_t;

    // Decode to memory
    typedef struct packed {
        logic [31:0] addr;
        size_e       size;
        logic        is_store;
        logic        sign_ext;
        logic [31:0] wdata;
        logic [4:0]  rd;
        logic        err;
    } mem_cmd_t;

    // Memory to formatter, raw bytes lowest first
    typedef struct packed {
        logic [31:0] rword;
        size_e       size;
        logic        sign_ext;
        logic        is_store;
        logic [4:0]  rd;
        logic        err;
    } mem_rsp_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic [4:0]  rd;
        logic        is_store;
        logic        err;
    } lsu_rsp_t;

endpackage

`default_nettype wire

/* lsu_top.f */
lsu_pkg.sv
lsu_decode.sv
data_mem.sv
load_format.sv
lsu_top.sv
lsu_checker.sv
tb_lsu_top.sv

/* lsu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_top import lsu_pkg::*; (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     req_valid_i,
    input  lsu_req_t req_i,
    output logic     rsp_valid_o,
    output lsu_rsp_t rsp_o
);

    // Stage 1 to stage 2
    logic     cmd_valid;
    mem_cmd_t cmd;

    // Stage 2 to stage 3
    logic     mrsp_valid;
    mem_rsp_t mrsp;

    // Address, size and access checks
    lsu_decode decode_i (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .cmd_valid_o (cmd_valid),
        .cmd_o       (cmd)
    );

    data_mem data_mem_i (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .cmd_valid_i  (cmd_valid),
        .cmd_i        (cmd),
        .mrsp_valid_o (mrsp_valid),
        .mrsp_o       (mrsp)
    );

    // Extension and error pattern
    load_format load_format_i (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .mrsp_valid_i (mrsp_valid),
        .mrsp_i       (mrsp),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_o        (rsp_o)
    );

endmodule

`default_nettype wire

/* tb_lsu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_lsu_top import lsu_pkg::*; ();

    logic       clk = 1'b0;
    logic       arst_n_i;
    logic       req_valid_i;
    lsu_req_t   req_i;
    logic       rsp_valid_o;
    lsu_rsp_t   rsp_o;

    logic [7:0] model_mem [int unsigned];   // Reference bytes written so far
    lsu_rsp_t   exp_q [$];
    int         issue_q [$];                // Negedge count when each request left
    int         edge_cnt       = 0;
    int         check_errors   = 0;
    int         timeout_errors = 0;

    always #4 clk = ~clk;

    lsu_top lsu_top_i (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o)
    );

    bind lsu_top lsu_checker lsu_checker_i (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .req_valid_i (req_valid_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o)
    );

    function automatic lsu_req_t make_req(input logic [6:0] opc, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [31:0] base,
                                          input logic [11:0] imm, input logic [31:0] data);
        lsu_req_t r;
        r.rs1_val = base;
        r.rs2_val = data;
        if (opc == OPC_STORE) begin
            r.instr.s = '{imm[11:5], 5'd2, 5'd1, f3, imm[4:0], opc};
        end else begin
            r.instr.i = '{imm, 5'd1, f3, rd, opc};   // Loads and illegal opcodes
        end
        return r;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            check_errors++;
            $display("[ERROR] %s: expected 0x%h, got 0x%h", name, exp, got);
        end
    endtask

    // Predicts the response and updates the model before driving the request
    task automatic send(input lsu_req_t r);
        logic [31:0] w;
        logic [31:0] addr;
        logic [31:0] val;
        int          nbytes;
        logic        legal;
        lsu_rsp_t    e;
        w          = r.instr;
        e.is_store = (w[6:0] == OPC_STORE);
        e.rd       = e.is_store ? 5'd0 : w[11:7];
        addr       = r.rs1_val + (e.is_store ? {{20{w[31]}}, w[31:25], w[11:7]}
                                             : {{20{w[31]}}, w[31:20]});
        nbytes     = 1 << w[13:12];
        if (e.is_store) begin
            legal = (w[14:12] inside {F3_B, F3_H, F3_W});
        end else begin
            legal = (w[6:0] == OPC_LOAD) && (w[14:12] inside {F3_B, F3_H, F3_W, F3_BU, F3_HU});
        end
        e.err = !legal || (addr > TOP_ADDR) || (addr % nbytes != 0);
        val   = '0;
        for (int k = nbytes - 1; k >= 0 && !e.err; k--) begin
            if (e.is_store) begin
                model_mem[addr + k] = r.rs2_val[8*k +: 8];
            end else begin
                val = {val[23:0], model_mem[addr + k]};
            end
        end
        if (!w[14] && nbytes < 4 && val[8*nbytes-1]) begin
            val = val | (32'hFFFF_FFFF << (8 * nbytes));   // Signed byte or half
        end
        e.rdata = e.err ? ERR_PATTERN : val;
        @(posedge clk);
        req_valid_i <= 1'b1;
        req_i       <= r;
        exp_q.push_back(e);
        issue_q.push_back(edge_cnt);
    endtask

    // Ends a burst and waits for all outstanding responses
    task automatic drain();
        int cycles;
        cycles = 0;
        @(posedge clk);
        req_valid_i <= 1'b0;
        while (exp_q.size() != 0 && cycles < 10) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            timeout_errors++;
            $display("No response arrived for %0d requests", exp_q.size());
            exp_q.delete();
            issue_q.delete();
        end
    endtask

    // Responses come back in request order
    always @(negedge clk) begin : monitor
        lsu_rsp_t e;
        if (arst_n_i && rsp_valid_o) begin
            if (exp_q.size() == 0) begin
                check_errors++;
                $display("Response arrived with no request outstanding");
            end else begin
                e = exp_q.pop_front();
                check_field("latency", edge_cnt - issue_q.pop_front(), PIPE_LATENCY);
                check_field("rsp_o.rdata", rsp_o.rdata, e.rdata);
                check_field("rsp_o.rd", rsp_o.rd, e.rd);
                check_field("rsp_o.is_store", rsp_o.is_store, e.is_store);
                check_field("rsp_o.err", rsp_o.err, e.err);
            end
        end
        edge_cnt++;
    end

    initial begin : stimulus
        logic [31:0] addr;
        logic [11:0] imm;
        void'($urandom(32'h78a51729));
        arst_n_i    = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        repeat (5) @(posedge clk);
        arst_n_i <= 1'b1;
        repeat (10) @(posedge clk);   // Idle with no request outstanding

        // Word store then word load at random addresses with random immediates
        for (int n = 0; n < 8; n++) begin
            addr = ($urandom % (MEM_BYTES / 4)) * 4;
            imm  = 12'($urandom) & 12'hFFC;
            send(make_req(OPC_STORE, F3_W, 5'd0, addr - {{20{imm[11]}}, imm}, imm, $urandom));
            imm  = 12'($urandom) & 12'hFFC;
            send(make_req(OPC_LOAD, F3_W, 5'(n + 1), addr - {{20{imm[11]}}, imm}, imm, 32'h0));
        end
        drain();

        // Partial stores into one word
        send(make_req(OPC_STORE, F3_W, 5'd0, 32'h100, 12'h000, 32'h1122_3344));
        send(make_req(OPC_STORE, F3_B, 5'd0, 32'h110, 12'hFF1, 32'hABCD_EF80));
        send(make_req(OPC_STORE, F3_H, 5'd0, 32'h100, 12'h002, 32'h1234_9ABC));
        send(make_req(OPC_LOAD, F3_W, 5'd1, 32'h100, 12'h000, 32'h0));
        send(make_req(OPC_LOAD, F3_B, 5'd2, 32'h100, 12'h001, 32'h0));
        send(make_req(OPC_LOAD, F3_BU, 5'd3, 32'h104, 12'hFFD, 32'h0));
        send(make_req(OPC_LOAD, F3_H, 5'd4, 32'h100, 12'h002, 32'h0));
        send(make_req(OPC_LOAD, F3_HU, 5'd5, 32'h100, 12'h002, 32'h0));
        send(make_req(OPC_LOAD, F3_H, 5'd6, 32'h100, 12'h000, 32'h0));
        drain();

        // Erroneous accesses leave memory untouched
        send(make_req(OPC_STORE, F3_W, 5'd0, 32'h0, 12'h000, 32'hCAFE_0001));
        send(make_req(OPC_STORE, F3_W, 5'd0, 32'h200, 12'h000, 32'hCAFE_0200));
        send(make_req(OPC_STORE, F3_H, 5'd0, 32'h200, 12'h001, 32'h1111_1111));
        send(make_req(OPC_STORE, F3_W, 5'd0, 32'h200, 12'h002, 32'h2222_2222));
        send(make_req(OPC_LOAD, F3_W, 5'd4, 32'h1FE, 12'h004, 32'h0));
        send(make_req(OPC_LOAD, F3_HU, 5'd5, 32'h204, 12'hFFF, 32'h0));
        send(make_req(OPC_STORE, F3_W, 5'd0, 32'h0002_0000, 12'h000, 32'hBAD0_BAD0));
        send(make_req(OPC_LOAD, F3_W, 5'd7, 32'h0, 12'hFFC, 32'h0));
        send(make_req(7'b0110011, F3_W, 5'd8, 32'h200, 12'h000, 32'h0));
        send(make_req(OPC_STORE, F3_BU, 5'd0, 32'h200, 12'h000, 32'h3333_3333));
        send(make_req(OPC_LOAD, 3'b011, 5'd9, 32'h200, 12'h000, 32'h0));
        send(make_req(OPC_LOAD, F3_W, 5'd10, 32'h0, 12'h000, 32'h0));
        send(make_req(OPC_LOAD, F3_W, 5'd11, 32'h200, 12'h000, 32'h0));
        drain();

        // Load right behind a store to the same address
        send(make_req(OPC_STORE, F3_W, 5'd0, 32'h300, 12'h000, 32'h5566_7788));
        send(make_req(OPC_LOAD, F3_W, 5'd12, 32'h300, 12'h000, 32'h0));
        send(make_req(OPC_STORE, F3_B, 5'd0, 32'h300, 12'h003, 32'h0000_00EE));
        send(make_req(OPC_LOAD, F3_BU, 5'd13, 32'h303, 12'h000, 32'h0));
        send(make_req(OPC_LOAD, F3_W, 5'd14, 32'h300, 12'h000, 32'h0));
        drain();
        repeat (2) @(posedge clk);    // Checker samples the last response

        $display("Errors: %0d failed checks, %0d timeouts, %0d assertion failures",
                 check_errors, timeout_errors, lsu_top_i.lsu_checker_i.fail_cnt);
        if (check_errors == 0 && timeout_errors == 0 &&
            lsu_top_i.lsu_checker_i.fail_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
